/* project.f */
hw/mac_pkg.sv
hw/math_multiplier_basic_cell.sv
hw/math_multiplier_carry_save.sv
hw/mac_input_stage.sv
hw/mac_accumulator.sv
hw/mac_unit.sv
test/tb_clock_gen.sv
test/tb_mac_unit.sv

/* Bender.yml */
package:
  name: mac_unit

sources:
  # package first, then leaf cells up to the top level
  - hw/mac_pkg.sv
  - hw/math_multiplier_basic_cell.sv
  - hw/math_multiplier_carry_save.sv
  - hw/mac_input_stage.sv
  - hw/mac_accumulator.sv
  - hw/mac_unit.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_mac_unit.sv

/* test/tb_mac_unit.sv */
module tb_mac_unit;

    // cycle limits for every wait loop
    localparam int RESET_TIMEOUT = 10;
    localparam int START_TIMEOUT = 20;
    localparam int DONE_TIMEOUT  = 8;
    localparam int END_TIMEOUT   = 400;
    // quiet cycles watched after the last result
    localparam int TAIL_CYCLES   = 5;
    localparam int RANDOM_COUNT  = 32;

    logic                            clk;
    logic                            rst_n;
    logic                            start;
    mac_pkg::mac_op_e                op;
    logic [mac_pkg::OPERAND_W-1:0]   multiplier;
    logic [mac_pkg::OPERAND_W-1:0]   multiplicand;
    logic                            done;
    logic [mac_pkg::ACC_W-1:0]       acc;
    logic                            overflow;

    // stimulus table, one row per operation
    string                           tbl_name[$];
    mac_pkg::mac_op_e                tbl_op[$];
    logic [mac_pkg::OPERAND_W-1:0]   tbl_a[$];
    logic [mac_pkg::OPERAND_W-1:0]   tbl_b[$];
    // idle cycles after the row, zero means back-to-back
    int                              tbl_gap[$];
    // expected result columns, filled by the model
    logic [mac_pkg::ACC_W-1:0]       tbl_exp_acc[$];
    logic                            tbl_exp_ovf[$];

    int          mismatches;
    int          timeouts;
    logic        run_started;
    logic        check_finished;
    logic [31:0] rng_state;

    tb_clock_gen tb_clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mac_unit mac_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .op           (op),
        .multiplier   (multiplier),
        .multiplicand (multiplicand),
        .done         (done),
        .acc          (acc),
        .overflow     (overflow)
    );

    // 32 bit xorshift, shifts 13 17 5
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_entry(
        input string                         name,
        input mac_pkg::mac_op_e              entry_op,
        input logic [mac_pkg::OPERAND_W-1:0] a,
        input logic [mac_pkg::OPERAND_W-1:0] b,
        input int                            gap
    );
        tbl_name.push_back(name);
        tbl_op.push_back(entry_op);
        tbl_a.push_back(a);
        tbl_b.push_back(b);
        tbl_gap.push_back(gap);
    endtask

    task automatic build_table();
        logic [31:0] r;
        // plain products, spaced out
        add_entry("mul_zero", mac_pkg::OP_MUL, 8'd0, 8'd37, 1);
        add_entry("mul_one", mac_pkg::OP_MUL, 8'd1, 8'd200, 1);
        add_entry("mul_max", mac_pkg::OP_MUL, 8'd255, 8'd255, 1);
        add_entry("mul_mid", mac_pkg::OP_MUL, 8'd12, 8'd13, 1);
        // clear ignores operands
        add_entry("clr_first", mac_pkg::OP_CLR, 8'd99, 8'd77, 1);
        // short accumulate run, back-to-back
        add_entry("mac_a", mac_pkg::OP_MAC, 8'd3, 8'd4, 0);
        add_entry("mac_b", mac_pkg::OP_MAC, 8'd10, 8'd20, 0);
        add_entry("mac_c", mac_pkg::OP_MAC, 8'd100, 8'd100, 0);
        add_entry("mac_d", mac_pkg::OP_MAC, 8'd7, 8'd9, 1);
        add_entry("clr_second", mac_pkg::OP_CLR, 8'd255, 8'd255, 1);
        // 17th add of 65025 passes 2^20
        for (int k = 0; k < 20; k++) begin
            add_entry($sformatf("ovf_%0d", k), mac_pkg::OP_MAC, 8'd255, 8'd255, 0);
        end
        // load keeps the flag, only a clear drops it
        add_entry("mul_after_ovf", mac_pkg::OP_MUL, 8'd2, 8'd3, 1);
        add_entry("clr_after_ovf", mac_pkg::OP_CLR, 8'd5, 8'd6, 1);
        // random operands, mostly loads with some adds
        rng_state = 32'd82;
        for (int k = 0; k < RANDOM_COUNT; k++) begin
            rng_state = xorshift32(rng_state);
            r = rng_state;
            add_entry($sformatf("rnd_%0d", k),
                      (r[17:16] == 2'b11) ? mac_pkg::OP_MAC : mac_pkg::OP_MUL,
                      r[7:0], r[15:8], r[20]);
        end
    endtask

    // reference model over the whole table
    task automatic fill_expected();
        logic [mac_pkg::ACC_W-1:0]     model_acc;
        logic                          model_ovf;
        logic [mac_pkg::PRODUCT_W-1:0] prod;
        logic [mac_pkg::ACC_W:0]       sum;
        model_acc = '0;
        model_ovf = 1'b0;
        for (int i = 0; i < tbl_name.size(); i++) begin
            prod = tbl_a[i] * tbl_b[i];
            sum  = {1'b0, model_acc} + prod;
            if (tbl_op[i] == mac_pkg::OP_MUL) begin
                model_acc = prod;
            end else if (tbl_op[i] == mac_pkg::OP_MAC) begin
                // wrap, carry out is sticky
                model_acc = sum[mac_pkg::ACC_W-1:0];
                model_ovf = model_ovf | sum[mac_pkg::ACC_W];
            end else begin
                model_acc = '0;
                model_ovf = 1'b0;
            end
            tbl_exp_acc.push_back(model_acc);
            tbl_exp_ovf.push_back(model_ovf);
        end
    endtask

    // main sequence and drive loop
    initial begin
        int waited;
        start          = 1'b0;
        op             = mac_pkg::OP_MUL;
        multiplier     = '0;
        multiplicand   = '0;
        mismatches     = 0;
        timeouts       = 0;
        run_started    = 1'b0;
        check_finished = 1'b0;
        build_table();
        fill_expected();

        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("reset was never released");
        end

        // state right after reset
        @(negedge clk);
        if (done !== 1'b0) begin
            mismatches++;
            $display("MISMATCH reset_state done expected 0 actual %b", done);
        end
        if (acc !== '0) begin
            mismatches++;
            $display("MISMATCH reset_state acc expected 0 actual %0h", acc);
        end
        if (overflow !== 1'b0) begin
            mismatches++;
            $display("MISMATCH reset_state overflow expected 0 actual %b", overflow);
        end
        run_started = 1'b1;

        for (int i = 0; i < tbl_name.size(); i++) begin
            @(posedge clk);
            start        <= 1'b1;
            op           <= tbl_op[i];
            multiplier   <= tbl_a[i];
            multiplicand <= tbl_b[i];
            for (int g = 0; g < tbl_gap[i]; g++) begin
                @(posedge clk);
                start <= 1'b0;
            end
        end
        @(posedge clk);
        start <= 1'b0;

        // wait for the checker to count every result
        waited = 0;
        while (!check_finished && waited < END_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (!check_finished) begin
            timeouts++;
            $display("checker did not finish counting results in time");
        end

        $display("mismatches %0d timeouts %0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // checker, one table row per done strobe, sampled on the falling edge
    initial begin
        int   waited;
        int   idx;
        logic seen;
        logic abort;
        waited = 0;
        abort  = 1'b0;
        while (run_started !== 1'b1 && waited < START_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (run_started !== 1'b1) begin
            timeouts++;
            $display("stimulus never started");
            abort = 1'b1;
        end

        idx = 0;
        while (!abort && idx < tbl_name.size()) begin
            waited = 0;
            seen   = 1'b0;
            while (!seen && waited < DONE_TIMEOUT) begin
                @(negedge clk);
                if (done === 1'b1) begin
                    seen = 1'b1;
                end else begin
                    waited++;
                end
            end
            if (!seen) begin
                timeouts++;
                $display("no done strobe for entry %0d (%s)", idx, tbl_name[idx]);
                abort = 1'b1;
            end else begin
                if (acc !== tbl_exp_acc[idx]) begin
                    mismatches++;
                    $display("MISMATCH %s acc expected %0h actual %0h",
                             tbl_name[idx], tbl_exp_acc[idx], acc);
                end
                if (overflow !== tbl_exp_ovf[idx]) begin
                    mismatches++;
                    $display("MISMATCH %s overflow expected %b actual %b",
                             tbl_name[idx], tbl_exp_ovf[idx], overflow);
                end
                idx++;
            end
        end

        // one strobe per entry, nothing extra afterwards
        if (!abort) begin
            for (int t = 0; t < TAIL_CYCLES; t++) begin
                @(negedge clk);
                if (done === 1'b1) begin
                    mismatches++;
                    $display("extra done strobe after the last expected result");
                end
            end
        end
        check_finished = 1'b1;
    end

endmodule : tb_mac_unit

/* test/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    // 20 unit period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held low for the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule : tb_clock_gen

/* hw/mac_unit.sv */
module mac_unit (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  mac_pkg::mac_op_e                 op,
    input  logic [mac_pkg::OPERAND_W-1:0]    multiplier,
    input  logic [mac_pkg::OPERAND_W-1:0]    multiplicand,
    output logic                             done,
    output logic [mac_pkg::ACC_W-1:0]        acc,
    output logic                             overflow
);
    // registered operands into the array
    logic [mac_pkg::OPERAND_W-1:0] a_q;
    logic [mac_pkg::OPERAND_W-1:0] b_q;

    // registered operation and its valid bit
    mac_pkg::mac_op_e op_q;
    logic             valid_q;

    // array output, same cycle as the operands
    logic [mac_pkg::PRODUCT_W-1:0] product;

    // stage 1
    // sample start, operands and op
    mac_input_stage mac_input_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .op           (op),
        .multiplier   (multiplier),
        .multiplicand (multiplicand),
        .a_q          (a_q),
        .b_q          (b_q),
        .op_q         (op_q),
        .valid_q      (valid_q)
    );

    // combinational array between the two register stages
    math_multiplier_carry_save #(
        .N (mac_pkg::OPERAND_W)
    ) math_multiplier_carry_save_inst (
        .multiplier   (a_q),
        .multiplicand (b_q),
        .product      (product)
    );

    // stage 2
    // commit to acc and flag the result
    mac_accumulator mac_accumulator_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .product  (product),
        .op_q     (op_q),
        .valid_q  (valid_q),
        .done     (done),
        .acc      (acc),
        .overflow (overflow)
    );

endmodule : mac_unit

/* hw/mac_accumulator.sv */
module mac_accumulator (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [mac_pkg::PRODUCT_W-1:0]    product,
    input  mac_pkg::mac_op_e                 op_q,
    input  logic                             valid_q,
    output logic                             done,
    output logic [mac_pkg::ACC_W-1:0]        acc,
    output logic                             overflow
);
    // product widened to accumulator width
    logic [mac_pkg::ACC_W-1:0] product_ext;

    // add with one spare bit to catch the carry out
    logic [mac_pkg::ACC_W:0] sum_ext;

    // next state
    logic [mac_pkg::ACC_W-1:0] acc_d;
    logic                      overflow_d;

    assign product_ext = {{mac_pkg::ACC_PAD_W{1'b0}}, product};

    assign sum_ext = {1'b0, acc} + {1'b0, product_ext};

    // operation select
    always_comb begin
        // hold unless an operation commits
        acc_d      = acc;
        overflow_d = overflow;
        if (valid_q) begin
            case (op_q)
                mac_pkg::OP_MUL: begin
                    // load leaves overflow alone
                    acc_d = product_ext;
                end
                mac_pkg::OP_MAC: begin
                    // wraps at ACC_W bits
                    acc_d      = sum_ext[mac_pkg::ACC_W-1:0];
                    // sticky until a clear
                    overflow_d = overflow | sum_ext[mac_pkg::ACC_W];
                end
                mac_pkg::OP_CLR: begin
                    acc_d      = '0;
                    overflow_d = 1'b0;
                end
                default: begin
                    // unused encoding changes nothing
                    acc_d      = acc;
                    overflow_d = overflow;
                end
            endcase
        end
    end

    // result registers and done strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc      <= '0;
            overflow <= 1'b0;
            done     <= 1'b0;
        end else begin
            acc      <= acc_d;
            overflow <= overflow_d;
            // done marks the cycle after commit
            done     <= valid_q;
        end
    end

    // done only ever follows a valid by one cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(valid_q))
        else $error("done without a valid one cycle earlier");

    // overflow only appears together with a result
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(overflow) |-> done)
        else $error("overflow rose on a cycle without done");

endmodule : mac_accumulator

/* hw/mac_input_stage.sv */
module mac_input_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  mac_pkg::mac_op_e                 op,
    input  logic [mac_pkg::OPERAND_W-1:0]    multiplier,
    input  logic [mac_pkg::OPERAND_W-1:0]    multiplicand,
    output logic [mac_pkg::OPERAND_W-1:0]    a_q,
    output logic [mac_pkg::OPERAND_W-1:0]    b_q,
    output mac_pkg::mac_op_e                 op_q,
    output logic                             valid_q
);

    // valid and operation
    // one operation per start, no stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            op_q    <= mac_pkg::OP_MUL;
        end else begin
            valid_q <= start;
            if (start) begin
                op_q <= op;
            end
        end
    end

    // operand capture
    // held on idle cycles so the array stays quiet
    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= multiplier;
            b_q <= multiplicand;
        end
    end

    // every accepted operation needs a defined opcode
    // otherwise the accumulator picks no path one cycle later
    assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !$isunknown(op))
        else $error("op unknown while start is high");

endmodule : mac_input_stage

/* hw/math_multiplier_carry_save.sv */
module math_multiplier_carry_save #(
    parameter int N = 4
) (
    input  logic [  N-1:0] multiplier,
    input  logic [  N-1:0] multiplicand,
    output logic [2*N-1:0] product
);
    // carries entering each row
    // row N holds the leftover carry vector
    wire [N:0][N-1:0] carry_row;

    // partial sums entering each row, already shifted one place right
    // row N holds the leftover sum vector
    wire [N:0][N-1:0] sum_row;

    // raw sum out of every cell, before the shift
    wire [N-1:0][N-1:0] cell_sum;

    // one finished low product bit per row
    wire [N-1:0] low_half;

    // upper half from the final carry-propagate add
    wire [N-1:0] high_half;

    // first row starts from nothing
    assign carry_row[0] = '0;
    assign sum_row[0]   = '0;

    for (genvar r = 0; r < N; r++) begin : gen_row
        for (genvar k = 0; k < N; k++) begin : gen_col
            // tile weight is 2^(r+k)
            math_multiplier_basic_cell cell_inst (
                .i     (multiplier[r]),
                .j     (multiplicand[k]),
                .c     (carry_row[r][k]),
                .p     (sum_row[r][k]),
                .c_out (carry_row[r+1][k]),
                .p_out (cell_sum[r][k])
            );

            if (k == 0) begin : gen_tap
                // lowest sum of the row is final
                assign low_half[r] = cell_sum[r][0];
            end else begin : gen_shift
                // keeps its weight in the next row one column lower
                assign sum_row[r+1][k-1] = cell_sum[r][k];
            end
        end

        // nothing shifts into the top column
        assign sum_row[r+1][N-1] = 1'b0;
    end

    // resolve the carry-save pair left after the last row
    // the true product fits 2N bits, so no carry leaves this add
    assign high_half = sum_row[N] + carry_row[N];

    assign product = {high_half, low_half};

endmodule : math_multiplier_carry_save

/* hw/math_multiplier_basic_cell.sv */
module math_multiplier_basic_cell (
    input  logic i,
    input  logic j,
    input  logic c,
    input  logic p,
    output logic c_out,
    output logic p_out
);
    // partial product bit for this tile
    logic pp;

    assign pp = i & j;

    // full adder over partial product, incoming sum and incoming carry
    assign p_out = pp ^ p ^ c;

    // majority of the three inputs
    assign c_out = (pp & p) | (pp & c) | (p & c);

endmodule : math_multiplier_basic_cell

/* hw/mac_pkg.sv */
package mac_pkg;

    // operand width seen by the caller
    // both operands share it
    localparam int OPERAND_W = 8;

    // full unsigned product of two operands
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // accumulator width
    // only a few bits above the product so a short run of
    // large products will wrap it
    localparam int ACC_W = 20;

    // zero bits needed to widen a product to accumulator width
    localparam int ACC_PAD_W = ACC_W - PRODUCT_W;

    // operation select
    // sampled with the operands on start
    typedef enum logic [1:0] {
        // acc takes the product
        OP_MUL = 2'd0,
        // acc adds the product, carry out sets overflow
        OP_MAC = 2'd1,
        // acc and overflow cleared, operands ignored
        OP_CLR = 2'd2
    } mac_op_e;

endpackage : mac_pkg
